/* Bender.yml */
package:
  name: axi_mem_if

sources:
  - include_dirs:
      - .
    files:
      - axi_mem_pkg.sv
      - burst_if.sv
      - axi_chan_fifo.sv
      - axi_burst_tracker.sv
      - axi_mem_ctrl.sv
      - axi_mem_if.sv
  - target: test
    include_dirs:
      - .
    files:
      - axi_mem_tb_clk.sv
      - axi_mem_tb.sv

/* axi_burst_tracker.sv */
`timescale 1ns/1ns
`include "axi_mem_params.svh"

module axi_burst_tracker (
  input logic      ACLK,
  input logic      ARESETn,
  burst_if.tracker bus
);

  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_ADDR_W-1:0] start_addr_q;
  logic [`AXI_LEN_W-1:0]  beat_idx_q;
  logic [`AXI_LEN_W-1:0]  remain_q;

  // ---------------------------------------------------------------------------
  // Beat counters
  // ---------------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      beat_idx_q <= '0;
      remain_q   <= '0;
    end else if (bus.load) begin
      beat_idx_q <= '0;
      remain_q   <= bus.req.len;
    end else if (bus.step) begin
      beat_idx_q <= beat_idx_q + 1'b1;
      remain_q   <= remain_q - 1'b1;
    end
  end

  // Request fields, held for the whole burst
  always_ff @(posedge ACLK) begin
    if (bus.load) begin
      id_q         <= bus.req.id;
      start_addr_q <= bus.req.addr;
    end
  end

  // ---------------------------------------------------------------------------
  // Beat view
  // ---------------------------------------------------------------------------
  // INCR only, one data word per beat
  assign bus.beat_addr = start_addr_q + (`AXI_ADDR_W'(beat_idx_q) << `AXI_BYTE_SHIFT);
  assign bus.id        = id_q;
  assign bus.last      = (remain_q == '0);

  // Controller stops stepping on the final beat
  a_no_step_past_last: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bus.step |-> !bus.last);

endmodule

/* axi_chan_fifo.sv */
`timescale 1ns/1ns
`include "axi_mem_params.svh"

module axi_chan_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = `AXI_FIFO_DEPTH
) (
  input  logic ACLK,
  input  logic ARESETn,
  input  logic push_valid_i,
  output logic push_ready_o,
  input  T     push_data_i,
  output logic pop_valid_o,
  input  logic pop_ready_i,
  output T     pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head entry must hold until the consumer takes it
  a_pop_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o));

endmodule

/* axi_mem_ctrl.sv */
`timescale 1ns/1ns
`include "axi_mem_params.svh"

module axi_mem_ctrl import axi_mem_pkg::*; (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  burst_req_t             aw_req_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  burst_req_t             ar_req_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  w_beat_t                w_beat_i,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output b_resp_t                b_resp_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output r_beat_t                r_beat_o,
  burst_if.ctrl                  wr_bus,
  burst_if.ctrl                  rd_bus,
  output logic                   mem_cen_o,
  output logic                   mem_wen_o,
  output logic [`AXI_ADDR_W-1:0] mem_addr_o,
  output logic [`AXI_DATA_W-1:0] mem_wdata_o,
  output logic [`AXI_STRB_W-1:0] mem_be_o,
  input  logic [`AXI_DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WRESP,
    ST_READ
  } state_e;

  state_e state_q;
  state_e state_d;
  // Alternates every cycle with 0 favouring reads
  logic   prio_q;
  // Read issued last cycle whose data arrives now
  logic   rd_pend_q;
  logic   pick_rd;
  logic   pick_wr;
  logic   wr_en;
  logic   wr_step;
  logic   rd_issue;
  logic   rd_step;

  // ---------------------------------------------------------------------------
  // Transfer FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    pick_rd  = 1'b0;
    pick_wr  = 1'b0;
    wr_en    = 1'b0;
    wr_step  = 1'b0;
    rd_issue = 1'b0;
    rd_step  = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (ar_valid_i && (!prio_q || !aw_valid_i)) begin
          pick_rd = 1'b1;
          state_d = ST_READ;
        end else if (aw_valid_i) begin
          pick_wr = 1'b1;
          state_d = ST_WRITE;
        end
      end

      ST_WRITE: begin
        if (w_valid_i) begin
          wr_en = 1'b1;
          if (wr_bus.last) begin
            state_d = ST_WRESP;
          end else begin
            wr_step = 1'b1;
          end
        end
      end

      ST_WRESP: begin
        if (b_ready_i) begin
          state_d = ST_IDLE;
        end
      end

      ST_READ: begin
        // Capture cycle leaves the SRAM idle so a beat takes two cycles
        if (rd_pend_q) begin
          if (rd_bus.last) begin
            state_d = ST_IDLE;
          end else begin
            rd_step = 1'b1;
          end
        end else if (r_ready_i) begin
          rd_issue = 1'b1;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q   <= ST_IDLE;
      prio_q    <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      prio_q    <= ~prio_q;
      rd_pend_q <= rd_issue;
    end
  end

  // ---------------------------------------------------------------------------
  // Channel and tracker sides
  // ---------------------------------------------------------------------------
  assign aw_ready_o = pick_wr;
  assign ar_ready_o = pick_rd;
  assign w_ready_o  = (state_q == ST_WRITE);

  assign wr_bus.load = pick_wr;
  assign wr_bus.step = wr_step;
  assign wr_bus.req  = aw_req_i;
  assign rd_bus.load = pick_rd;
  assign rd_bus.step = rd_step;
  assign rd_bus.req  = ar_req_i;

  assign b_valid_o = (state_q == ST_WRESP);
  assign b_resp_o  = '{id: wr_bus.id, resp: `AXI_RESP_OKAY};

  assign r_valid_o = rd_pend_q;
  assign r_beat_o  = '{
    id:   rd_bus.id,
    data: mem_rdata_i,
    resp: `AXI_RESP_OKAY,
    last: rd_bus.last
  };

  // SRAM port
  assign mem_cen_o   = !(wr_en || rd_issue);
  assign mem_wen_o   = !wr_en;
  assign mem_addr_o  = wr_en ? wr_bus.beat_addr : rd_bus.beat_addr;
  assign mem_wdata_o = w_beat_i.data;
  assign mem_be_o    = w_beat_i.strb;

  // Master and tracker must agree on where the burst ends
  a_wlast_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (state_q == ST_WRITE) && w_valid_i |-> (w_beat_i.last == wr_bus.last));

endmodule

/* axi_mem_if.sv */
`timescale 1ns/1ns
`include "axi_mem_params.svh"

module axi_mem_if import axi_mem_pkg::*; (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  logic [`AXI_ID_W-1:0]   aw_id_i,
  input  logic [`AXI_ADDR_W-1:0] aw_addr_i,
  input  logic [`AXI_LEN_W-1:0]  aw_len_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [`AXI_DATA_W-1:0] w_data_i,
  input  logic [`AXI_STRB_W-1:0] w_strb_i,
  input  logic                   w_last_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output logic [`AXI_ID_W-1:0]   b_id_o,
  output logic [1:0]             b_resp_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  input  logic [`AXI_ID_W-1:0]   ar_id_i,
  input  logic [`AXI_ADDR_W-1:0] ar_addr_i,
  input  logic [`AXI_LEN_W-1:0]  ar_len_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  output logic [`AXI_ID_W-1:0]   r_id_o,
  output logic [`AXI_DATA_W-1:0] r_data_o,
  output logic [1:0]             r_resp_o,
  output logic                   r_last_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic                   mem_cen_o,
  output logic                   mem_wen_o,
  output logic [`AXI_ADDR_W-1:0] mem_addr_o,
  output logic [`AXI_DATA_W-1:0] mem_wdata_o,
  output logic [`AXI_STRB_W-1:0] mem_be_o,
  input  logic [`AXI_DATA_W-1:0] mem_rdata_i
);

  burst_req_t aw_push;
  burst_req_t aw_req;
  logic       aw_valid;
  logic       aw_ready;
  burst_req_t ar_push;
  burst_req_t ar_req;
  logic       ar_valid;
  logic       ar_ready;
  w_beat_t    w_push;
  w_beat_t    w_beat;
  logic       w_valid;
  logic       w_ready;
  b_resp_t    b_resp;
  b_resp_t    b_pop;
  logic       b_valid;
  logic       b_ready;
  r_beat_t    r_beat;
  r_beat_t    r_pop;
  logic       r_valid;
  logic       r_ready;

  burst_if wr_bus ();
  burst_if rd_bus ();

  // Port packing
  assign aw_push = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i};
  assign ar_push = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i};
  assign w_push  = '{data: w_data_i, strb: w_strb_i, last: w_last_i};

  assign b_id_o   = b_pop.id;
  assign b_resp_o = b_pop.resp;
  assign r_id_o   = r_pop.id;
  assign r_data_o = r_pop.data;
  assign r_resp_o = r_pop.resp;
  assign r_last_o = r_pop.last;

  // ---------------------------------------------------------------------------
  // Channel buffers
  // ---------------------------------------------------------------------------
  axi_chan_fifo #(.T(burst_req_t), .DEPTH(`AXI_FIFO_DEPTH)) u_aw_fifo (
    .ACLK, .ARESETn,
    .push_valid_i (aw_valid_i),
    .push_ready_o (aw_ready_o),
    .push_data_i  (aw_push),
    .pop_valid_o  (aw_valid),
    .pop_ready_i  (aw_ready),
    .pop_data_o   (aw_req)
  );

  axi_chan_fifo #(.T(burst_req_t), .DEPTH(`AXI_FIFO_DEPTH)) u_ar_fifo (
    .ACLK, .ARESETn,
    .push_valid_i (ar_valid_i),
    .push_ready_o (ar_ready_o),
    .push_data_i  (ar_push),
    .pop_valid_o  (ar_valid),
    .pop_ready_i  (ar_ready),
    .pop_data_o   (ar_req)
  );

  axi_chan_fifo #(.T(w_beat_t), .DEPTH(`AXI_FIFO_DEPTH)) u_w_fifo (
    .ACLK, .ARESETn,
    .push_valid_i (w_valid_i),
    .push_ready_o (w_ready_o),
    .push_data_i  (w_push),
    .pop_valid_o  (w_valid),
    .pop_ready_i  (w_ready),
    .pop_data_o   (w_beat)
  );

  axi_chan_fifo #(.T(b_resp_t), .DEPTH(`AXI_FIFO_DEPTH)) u_b_fifo (
    .ACLK, .ARESETn,
    .push_valid_i (b_valid),
    .push_ready_o (b_ready),
    .push_data_i  (b_resp),
    .pop_valid_o  (b_valid_o),
    .pop_ready_i  (b_ready_i),
    .pop_data_o   (b_pop)
  );

  axi_chan_fifo #(.T(r_beat_t), .DEPTH(`AXI_FIFO_DEPTH)) u_r_fifo (
    .ACLK, .ARESETn,
    .push_valid_i (r_valid),
    .push_ready_o (r_ready),
    .push_data_i  (r_beat),
    .pop_valid_o  (r_valid_o),
    .pop_ready_i  (r_ready_i),
    .pop_data_o   (r_pop)
  );

  // ---------------------------------------------------------------------------
  // Burst trackers and controller
  // ---------------------------------------------------------------------------
  axi_burst_tracker u_wr_tracker (.ACLK, .ARESETn, .bus(wr_bus));
  axi_burst_tracker u_rd_tracker (.ACLK, .ARESETn, .bus(rd_bus));

  axi_mem_ctrl u_ctrl (
    .ACLK, .ARESETn,
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_req_i    (aw_req),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_req_i    (ar_req),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_beat_i    (w_beat),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .b_resp_o    (b_resp),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_beat_o    (r_beat),
    .wr_bus      (wr_bus),
    .rd_bus      (rd_bus),
    .mem_cen_o, .mem_wen_o, .mem_addr_o, .mem_wdata_o, .mem_be_o, .mem_rdata_i
  );

endmodule

/* axi_mem_params.svh */
`ifndef AXI_MEM_PARAMS_SVH
`define AXI_MEM_PARAMS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define AXI_ID_W       4
`define AXI_ADDR_W     16
`define AXI_DATA_W     32
`define AXI_STRB_W     4
`define AXI_LEN_W      8

// Log2 of bytes per data word, used to step beat addresses
`define AXI_BYTE_SHIFT 2

// ---------------------------------------------------------------------------
// Channel buffers and responses
// ---------------------------------------------------------------------------
`define AXI_FIFO_DEPTH 4

// Only response code the slave ever returns
`define AXI_RESP_OKAY  2'b00

`endif

/* axi_mem_pkg.sv */
`include "axi_mem_params.svh"

package axi_mem_pkg;

  // Address request, shared by AW and AR
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    // Beats minus one
    logic [`AXI_LEN_W-1:0]  len;
  } burst_req_t;

  // Write data beat
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } w_beat_t;

  // Write response
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } b_resp_t;

  // Read data beat
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } r_beat_t;

endpackage

/* axi_mem_tb.sv */
`timescale 1ns/1ns

module axi_mem_tb;

  localparam int MAX_BEATS = 1024;
  localparam int MEM_WORDS = 16384;

  logic        ACLK;
  logic        ARESETn;
  logic [3:0]  aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [15:0] aw_addr_i, ar_addr_i, mem_addr_o;
  logic [7:0]  aw_len_i, ar_len_i;
  logic [31:0] w_data_i, r_data_o, mem_wdata_o, mem_rdata_i;
  logic [3:0]  w_strb_i, mem_be_o;
  logic [1:0]  b_resp_o, r_resp_o;
  logic        aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic        b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
  logic        r_valid_o, r_ready_i, r_last_o, mem_cen_o, mem_wen_o;

  // SRAM model and shadow copy, word addressed
  logic [31:0] sram [MEM_WORDS];
  logic [31:0] shadow [MEM_WORDS];

  // Expected responses in issue order
  logic [3:0]  exp_b_id [MAX_BEATS];
  logic [3:0]  exp_r_id [MAX_BEATS];
  logic [31:0] exp_r_data [MAX_BEATS];
  logic        exp_r_last [MAX_BEATS];
  int          b_exp_wr, b_exp_rd, r_exp_wr, r_exp_rd;
  int          beats_issued;
  int          cycles;
  logic [31:0] wr_st, rd_st, rdy_st;
  logic        rdy_random;

  axi_mem_tb_clk u_clk (.ACLK, .ARESETn);

  axi_mem_if u_dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] st);
    return st * 32'd1664525 + 32'd1013904223;
  endfunction

  // Odd multiplier spreads every address bit over the word
  function automatic logic [31:0] fill_word(input int idx);
    return 32'(idx) * 32'h9e37_79b1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    int          b;
    res = old_w;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("error %0t: %s", $time, msg);
    stop_failed();
  endtask

  // ---------------------------------------------------------------------------
  // SRAM model, read data one cycle after the request
  // ---------------------------------------------------------------------------
  always @(posedge ACLK) begin
    if (!mem_cen_o && !mem_wen_o) begin
      sram[mem_addr_o[15:2]] <= merge_bytes(sram[mem_addr_o[15:2]], mem_wdata_o, mem_be_o);
    end else if (!mem_cen_o) begin
      mem_rdata_i <= sram[mem_addr_o[15:2]];
    end
  end

  // Back-pressure on B and R
  always @(negedge ACLK) begin
    if (rdy_random) begin
      rdy_st = lcg_next(rdy_st);
      r_ready_i = rdy_st[17] | rdy_st[19];
      b_ready_i = rdy_st[21] | rdy_st[23];
    end else begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end
  end

  always @(posedge ACLK) begin
    if (b_valid_o && b_ready_i) begin
      b_exp_rd <= b_exp_rd + 1;
    end
    if (r_valid_o && r_ready_i) begin
      r_exp_rd <= r_exp_rd + 1;
    end
  end

  // ---------------------------------------------------------------------------
  // Response checks
  // ---------------------------------------------------------------------------
  a_b_order: assert property (@(posedge ACLK) disable iff (!ARESETn)
    b_valid_o && b_ready_i |-> b_exp_rd < b_exp_wr && b_id_o == exp_b_id[b_exp_rd])
    else report_error("write response with wrong ID or none outstanding");

  a_b_okay: assert property (@(posedge ACLK) disable iff (!ARESETn)
    b_valid_o |-> b_resp_o == 2'b00)
    else report_error("write response is not OKAY");

  a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable({b_id_o, b_resp_o}))
    else report_error("write response changed before it was accepted");

  a_r_order: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_o && r_ready_i |-> r_exp_rd < r_exp_wr && r_id_o == exp_r_id[r_exp_rd]
      && r_last_o == exp_r_last[r_exp_rd])
    else report_error("read beat with wrong ID or last flag, or none outstanding");

  a_r_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_o && r_ready_i |-> r_data_o == exp_r_data[r_exp_rd])
    else report_error($sformatf("read data %h, expected %h", $sampled(r_data_o),
                                $sampled(exp_r_data[r_exp_rd])));

  a_r_okay: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_o |-> r_resp_o == 2'b00)
    else report_error("read response is not OKAY");

  a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_id_o, r_data_o, r_resp_o, r_last_o}))
    else report_error("read beat changed before it was accepted");

  // ---------------------------------------------------------------------------
  // Channel drivers, entered and left on a falling edge
  // ---------------------------------------------------------------------------
  task automatic drive_aw(input logic [3:0] id, input logic [15:0] addr, input logic [7:0] len);
    logic acc;
    aw_id_i = id;
    aw_addr_i = addr;
    aw_len_i = len;
    aw_valid_i = 1'b1;
    do begin
      acc = aw_ready_o;
      @(negedge ACLK);
    end while (!acc);
    aw_valid_i = 1'b0;
  endtask

  task automatic drive_w(input logic [31:0] data, input logic [3:0] strb, input logic last);
    logic acc;
    w_data_i = data;
    w_strb_i = strb;
    w_last_i = last;
    w_valid_i = 1'b1;
    do begin
      acc = w_ready_o;
      @(negedge ACLK);
    end while (!acc);
    w_valid_i = 1'b0;
  endtask

  task automatic drive_ar(input logic [3:0] id, input logic [15:0] addr, input logic [7:0] len);
    logic acc;
    ar_id_i = id;
    ar_addr_i = addr;
    ar_len_i = len;
    ar_valid_i = 1'b1;
    do begin
      acc = ar_ready_o;
      @(negedge ACLK);
    end while (!acc);
    ar_valid_i = 1'b0;
  endtask

  // A zero strobe argument picks a random strobe per beat
  task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                             input logic [7:0] len, input logic [3:0] strb);
    logic [13:0] widx;
    logic [3:0]  be;
    int          i;
    exp_b_id[b_exp_wr] = id;
    b_exp_wr++;
    beats_issued += int'(len) + 1;
    drive_aw(id, addr, len);
    for (i = 0; i <= int'(len); i++) begin
      wr_st = lcg_next(wr_st);
      be = (strb != 4'h0) ? strb : wr_st[27:24];
      wr_st = lcg_next(wr_st);
      widx = addr[15:2] + 14'(i);
      shadow[widx] = merge_bytes(shadow[widx], wr_st, be);
      drive_w(wr_st, be, i == int'(len));
    end
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [15:0] addr, input logic [7:0] len);
    int i;
    for (i = 0; i <= int'(len); i++) begin
      exp_r_id[r_exp_wr] = id;
      exp_r_data[r_exp_wr] = shadow[addr[15:2] + 14'(i)];
      exp_r_last[r_exp_wr] = (i == int'(len));
      r_exp_wr++;
    end
    beats_issued += int'(len) + 1;
    drive_ar(id, addr, len);
  endtask

  task automatic wait_idle();
    wait (b_exp_rd == b_exp_wr && r_exp_rd == r_exp_wr);
    @(negedge ACLK);
  endtask

  // Write and read streams run together on disjoint regions
  task automatic random_round(input logic [15:0] wr_base, input logic [15:0] rd_base,
                              input int bursts);
    int k;
    int j;
    fork
      for (k = 0; k < bursts; k++) begin
        wr_st = lcg_next(wr_st);
        write_burst(4'(k), wr_base + {6'h00, wr_st[23:16], 2'b00}, 8'(wr_st[26:24]), 4'h0);
      end
      for (j = 0; j < bursts; j++) begin
        rd_st = lcg_next(rd_st);
        read_burst(4'(j + 8), rd_base + {6'h00, rd_st[23:16], 2'b00}, 8'(rd_st[26:24]));
      end
    join
  endtask

  initial begin
    cycles = 0;
    while (cycles <= 40 * beats_issued + 1000) begin
      @(posedge ACLK);
      cycles++;
    end
    $display("Timeout after %0d cycles with transfers still outstanding", cycles);
    stop_failed();
  end

  initial begin
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    w_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_valid_i = 1'b0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    mem_rdata_i = '0;
    rdy_random = 1'b0;
    wr_st = 32'h66ab;
    rd_st = 32'h66ab ^ 32'h1;
    rdy_st = 32'h66ab ^ 32'h2;
    for (int i = 0; i < MEM_WORDS; i++) begin
      sram[i] = fill_word(i);
      shadow[i] = fill_word(i);
    end
    wait (ARESETn === 1'b1);
    @(negedge ACLK);

    // Single write, then single read of the same word
    write_burst(4'h1, 16'h0100, 8'd0, 4'hf);
    wait_idle();
    read_burst(4'h2, 16'h0100, 8'd0);
    wait_idle();

    // INCR burst of six beats
    write_burst(4'h3, 16'h0200, 8'd5, 4'hf);
    wait_idle();
    read_burst(4'h4, 16'h0200, 8'd5);
    wait_idle();

    // Partial strobe over a full word
    write_burst(4'h5, 16'h0300, 8'd0, 4'hf);
    write_burst(4'h6, 16'h0300, 8'd0, 4'b0101);
    wait_idle();
    read_burst(4'h7, 16'h0300, 8'd0);
    wait_idle();

    // Concurrent random traffic under back-pressure
    rdy_random = 1'b1;
    random_round(16'h1000, 16'h2000, 30);
    wait_idle();
    random_round(16'h2000, 16'h1000, 30);
    wait_idle();

    $display("Simulation passed");
    $finish;
  end

endmodule

/* axi_mem_tb_clk.sv */
`timescale 1ns/1ns

module axi_mem_tb_clk (
  output logic ACLK,
  output logic ARESETn
);

  // 20 ns period
  initial begin
    ACLK = 1'b0;
    forever #10 ACLK = ~ACLK;
  end

  // Held low for five cycles, released on a falling edge
  initial begin
    ARESETn = 1'b0;
    repeat (5) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;
  end

endmodule

/* build.f */
+incdir+.
axi_mem_pkg.sv
burst_if.sv
axi_chan_fifo.sv
axi_burst_tracker.sv
axi_mem_ctrl.sv
axi_mem_if.sv
axi_mem_tb_clk.sv
axi_mem_tb.sv

/* burst_if.sv */
`timescale 1ns/1ns
`include "axi_mem_params.svh"

interface burst_if import axi_mem_pkg::*; ();

  // Controller side
  logic                   load;
  logic                   step;
  burst_req_t             req;

  // Tracker side, valid the cycle after load or step
  logic [`AXI_ADDR_W-1:0] beat_addr;
  logic [`AXI_ID_W-1:0]   id;
  logic                   last;

  modport ctrl (
    output load,
    output step,
    output req,
    input  beat_addr,
    input  id,
    input  last
  );

  modport tracker (
    input  load,
    input  step,
    input  req,
    output beat_addr,
    output id,
    output last
  );

endinterface
